//--- Bender.yml
package:
  name: rv_fetch

sources:
  - logic/fetch_pkg.sv
  - logic/fetch_pc.sv
  - logic/fetch_if_stage.sv
  - logic/fetch_id_stage.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - test/fetch_assertions.sv
      - test/fetch_tb.sv

//--- logic/fetch_id_stage.sv
// decode stage: latches the fetch bus, resolves jal and sends the redirect
`timescale 1ns/1ps

module fetch_id_stage
  import fetch_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_reset,
  // allowin from execute
  input  logic          i_es_allowin,
  // from fetch
  input  logic          i_fs_to_ds_valid,
  input  fs_to_ds_bus_t i_fs_to_ds_bus,
  // back to fetch
  output logic          o_ds_allowin,
  output br_bus_t       o_br_bus,
  // to execute
  output logic          o_ds_to_es_valid,
  output fs_to_ds_bus_t o_ds_to_es_bus
);

  logic          ds_valid;
  logic          ds_allowin;
  fs_to_ds_bus_t ds_bus_q;
  logic [6:0]    opcode;
  logic          is_jal;
  logic [PC_WD-1:0] j_imm;
  logic          br_sel;

  assign ds_allowin = !ds_valid || i_es_allowin;

  assign opcode = ds_bus_q.inst[6:0];
  assign is_jal = (opcode == OPCODE_JAL);

  // imm[20|10:1|11|19:12] sits at inst[31|30:21|20|19:12]
  assign j_imm = {{43{ds_bus_q.inst[31]}},
                  ds_bus_q.inst[31],
                  ds_bus_q.inst[19:12],
                  ds_bus_q.inst[20],
                  ds_bus_q.inst[30:21],
                  1'b0};

  // only as the jal leaves decode
  assign br_sel = ds_valid && is_jal && i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid && !br_sel; // drop the wrong-path slot
    end
  end

  always_ff @(posedge i_clk) begin
    if (ds_allowin && i_fs_to_ds_valid) begin
      ds_bus_q <= i_fs_to_ds_bus;
    end
  end

  assign o_ds_allowin     = ds_allowin;
  assign o_br_bus         = '{br_sel: br_sel, br_target: ds_bus_q.pc + j_imm};
  assign o_ds_to_es_valid = ds_valid;
  assign o_ds_to_es_bus   = ds_bus_q;

endmodule

//--- logic/fetch_if_stage.sv
// fetch stage: valid and allowin flow, pc register and instruction half select
`timescale 1ns/1ps

module fetch_if_stage
  import fetch_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset,
  // allowin from decode
  input  logic                    i_ds_allowin,
  // redirect from decode
  input  br_bus_t                 i_br_bus,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  // to decode
  output logic                    o_fs_to_ds_valid,
  output fs_to_ds_bus_t           o_fs_to_ds_bus,
  // instruction sram request
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic               to_fs_valid;
  logic               fs_valid;
  logic               fs_allowin;
  logic [PC_WD-1:0]   fs_pc;
  logic [INST_WD-1:0] fs_inst;
  fetch_word_u        fetch_word;

  // pre-fetch always has a request once reset is gone
  assign to_fs_valid = ~i_reset;

  // empty after reset, otherwise move on when decode accepts
  assign fs_allowin = !fs_valid || i_ds_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= to_fs_valid;
    end
  end

  // pc reset has priority inside fetch_pc, so a load held during reset
  // keeps the reset vector read on the sram port
  fetch_pc u_pc (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_load           (fs_allowin),
    .i_br_bus         (i_br_bus),
    .o_pc             (fs_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  // sram word is 64-bit aligned, pc[2] picks the half
  assign fetch_word.raw = i_inst_sram_rdata;
  assign fs_inst        = fs_pc[2] ? fetch_word.half.hi : fetch_word.half.lo;

  assign o_fs_to_ds_valid = fs_valid;
  assign o_fs_to_ds_bus   = '{inst: fs_inst, pc: fs_pc};

endmodule

//--- logic/fetch_pc.sv
// program counter with next address selection toward the instruction sram
`timescale 1ns/1ps

module fetch_pc
  import fetch_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_load,           // fetch stage accepts a new pc
  input  br_bus_t                 i_br_bus,         // redirect from decode
  output logic [PC_WD-1:0]        o_pc,
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic [PC_WD-1:0] pc_q;
  logic [PC_WD-1:0] seq_pc;
  logic [PC_WD-1:0] next_pc;
  logic             pc_en;

  assign seq_pc  = pc_q + 64'd4;
  // jump target wins over the sequential address
  assign next_pc = i_br_bus.br_sel ? i_br_bus.br_target : seq_pc;
  assign pc_en   = i_load || i_br_bus.br_sel;

  // one address lookahead so the read is issued in the same cycle
  // the fetch register captures it
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q <= PC_RESETVAL - 64'd4; // first next_pc is the reset vector
    end else if (pc_en) begin
      pc_q <= next_pc;
    end
  end

  assign o_pc             = pc_q;
  assign o_inst_sram_ren  = pc_en;
  assign o_inst_sram_addr = next_pc; // same width as pc

endmodule

//--- logic/fetch_pkg.sv
// fetch package: instruction set widths, reset vector and the buses between stages
package fetch_pkg;

  localparam int INST_WD      = 32;
  localparam int PC_WD        = 64;
  localparam int SRAM_ADDR_WD = 64;
  localparam int SRAM_DATA_WD = 64;

  // first address fetched after reset
  localparam logic [PC_WD-1:0] PC_RESETVAL = 64'h8000_0000;

  // major opcode of jal
  localparam logic [6:0] OPCODE_JAL = 7'b110_1111;

  // redirect from decode back to fetch
  typedef struct packed {
    logic             br_sel;    // redirect this cycle
    logic [PC_WD-1:0] br_target; // jump destination
  } br_bus_t;

  // fetch to decode payload, also reused for decode to execute
  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [PC_WD-1:0]   pc;
  } fs_to_ds_bus_t;

  // two 32-bit instructions packed in one sram word
  typedef struct packed {
    logic [INST_WD-1:0] hi; // pc[2] set
    logic [INST_WD-1:0] lo; // pc[2] clear
  } fetch_pair_t;

  // one sram read word, seen either raw or as an instruction pair
  typedef union packed {
    logic [SRAM_DATA_WD-1:0] raw;
    fetch_pair_t             half;
  } fetch_word_u;

endpackage

//--- logic/fetch_top.sv
// fetch front end top: fetch and decode stages around an external instruction sram
`timescale 1ns/1ps

module fetch_top
  import fetch_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset,
  // downstream allowin
  input  logic                    i_es_allowin,
  // instruction sram
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  // to execute
  output logic                    o_ds_to_es_valid,
  output fs_to_ds_bus_t           o_ds_to_es_bus
);

  logic          fs_to_ds_valid;
  fs_to_ds_bus_t fs_to_ds_bus;
  logic          ds_allowin;
  br_bus_t       br_bus;

  fetch_if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_ds_allowin      (ds_allowin),
    .i_br_bus          (br_bus),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_to_ds_bus    (fs_to_ds_bus),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr)
  );

  // jal resolves here and redirects fetch
  fetch_id_stage u_id_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_es_allowin     (i_es_allowin),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_to_ds_bus   (fs_to_ds_bus),
    .o_ds_allowin     (ds_allowin),
    .o_br_bus         (br_bus),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es_bus   (o_ds_to_es_bus)
  );

endmodule

//--- rv_fetch.f
logic/fetch_pkg.sv
logic/fetch_pc.sv
logic/fetch_if_stage.sv
logic/fetch_id_stage.sv
logic/fetch_top.sv
test/fetch_assertions.sv
test/fetch_tb.sv

//--- test/fetch_assertions.sv
// decode stage flow assertions: redirect pulse, stall stability and reset behavior
`timescale 1ns/1ps

module fetch_assertions
  import fetch_pkg::*;
(
  input logic          i_clk,
  input logic          i_reset,
  input logic          i_es_allowin,
  input logic          i_ds_to_es_valid,
  input fs_to_ds_bus_t i_ds_to_es_bus,
  input br_bus_t       i_br_bus
);

  int unsigned fail_count = 0; // failed assertion count

  // a jal leaves decode once, so the redirect is a single pulse
  assert_br_pulse: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_br_bus.br_sel |=> !i_br_bus.br_sel
  ) else begin
    fail_count++;
    $error("br_sel high on two consecutive cycles");
  end

  assert_stall_hold: assert property (
    @(posedge i_clk) disable iff (i_reset)
    (i_ds_to_es_valid && !i_es_allowin) |=> (i_ds_to_es_valid && $stable(i_ds_to_es_bus))
  ) else begin
    fail_count++;
    $error("decode output changed while stalled");
  end

  // reset is synchronous, so valid drops one edge later
  assert_reset_empty: assert property (
    @(posedge i_clk) i_reset |=> !i_ds_to_es_valid
  ) else begin
    fail_count++;
    $error("decode output valid during reset");
  end

endmodule

bind fetch_id_stage fetch_assertions u_assertions (
  .i_clk            (i_clk),
  .i_reset          (i_reset),
  .i_es_allowin     (i_es_allowin),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_ds_to_es_bus   (o_ds_to_es_bus),
  .i_br_bus         (o_br_bus)
);

//--- test/fetch_stim.txt
# w <hex64>: program word, consecutive from 0x80000000, pc[2] set selects bits 63:32
# t <cycles> <bits>: test length and repeating allowin pattern, r <cycles>: random allowin
w 0020809300108093
w 0100006f00308093
w 0050809300408093
w 0070809300608093
w 00c000ef00808093
w 00a0809300908093
w fd1ff06f00b08093
w 00d0809300c08093
# straight run, every jal followed by one bubble
t 40 1
# fixed stall patterns
t 60 110
t 60 0110100
t 50 10
# random stall
r 160

//--- test/fetch_tb.sv
// fetch front end testbench: sram model, reference instruction stream and output checks
`timescale 1ns/1ps

module fetch_tb
  import fetch_pkg::*;
();

  logic                    clk;
  logic                    reset;
  logic                    es_allowin;
  logic [SRAM_DATA_WD-1:0] sram_rdata = '0;
  logic                    sram_ren;
  logic [SRAM_ADDR_WD-1:0] sram_addr;
  logic                    ds_to_es_valid;
  fs_to_ds_bus_t           ds_to_es_bus;

  logic [63:0]      image [0:63];   // program image, one sram word each
  int               num_words;
  int               num_tests;
  int               run_len [0:15];
  int               pat_len [0:15];
  logic [8*64-1:0]  pat_str [0:15]; // allowin bits as characters
  logic             pat_rand [0:15];
  integer           seed;
  int               limit_cycles = 0;
  int               total_errors;
  int               test_errors;
  int               tests_failed;

  fetch_top u_dut (
    .i_clk             (clk),
    .i_reset           (reset),
    .i_es_allowin      (es_allowin),
    .i_inst_sram_rdata (sram_rdata),
    .o_inst_sram_ren   (sram_ren),
    .o_inst_sram_addr  (sram_addr),
    .o_ds_to_es_valid  (ds_to_es_valid),
    .o_ds_to_es_bus    (ds_to_es_bus)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [63:0] fill_word(input logic [63:0] addr);
    fill_word = {addr[31:0], addr[63:32]} ^ addr ^ 64'h0bad_f00d_5eed_1234;
  endfunction

  function automatic logic [63:0] mem_word(input logic [63:0] addr);
    logic [63:0] offset;
    offset = addr - PC_RESETVAL;
    if (offset < 64'd512) mem_word = image[offset[8:3]];
    else mem_word = fill_word({addr[63:3], 3'b000});
  endfunction

  // upper half holds the instruction at pc[2] set
  function automatic logic [31:0] expected_inst(input logic [63:0] pc);
    logic [63:0] word;
    word = mem_word(pc);
    expected_inst = pc[2] ? word[63:32] : word[31:0];
  endfunction

  function automatic logic [63:0] jal_target(input logic [63:0] pc, input logic [31:0] inst);
    logic [20:0] imm;
    imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    jal_target = pc + {{43{imm[20]}}, imm};
  endfunction

  function automatic int count_chars(input logic [8*64-1:0] s);
    int n;
    n = 0;
    while (n < 64 && s[8*n +: 8] != 8'h00) n++;
    count_chars = n;
  endfunction

  function automatic logic is_all_high(input int t);
    is_all_high = !pat_rand[t];
    for (int i = 0; i < pat_len[t]; i++) begin
      if (pat_str[t][8*i +: 8] != "1") is_all_high = 1'b0;
    end
  endfunction

  function automatic logic allowin_at(input int t, input int cyc);
    logic [7:0] ch;
    if (pat_rand[t]) begin
      allowin_at = ($random(seed) & 3) != 0; // mostly high
    end else begin
      ch = pat_str[t][8*(pat_len[t] - 1 - (cyc % pat_len[t])) +: 8];
      allowin_at = (ch == "1");
    end
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  // synchronous read, rdata held while ren is low
  always @(posedge clk) begin : sram_model
    logic        rd_en;
    logic [63:0] rd_addr;
    rd_en   = sram_ren;
    rd_addr = sram_addr;
    #2;
    if (rd_en) sram_rdata = mem_word(rd_addr);
  end

  task automatic read_stimulus(output logic ok);
    integer          fd;
    integer          code;
    logic [8*64-1:0] tok;
    logic [8*256-1:0] line;
    logic [63:0]     word;
    int              cycles;
    logic            done;
    ok = 1'b0;
    num_words = 0;
    num_tests = 0;
    fd = $fopen("test/fetch_stim.txt", "r");
    if (fd == 0) return;
    done = 1'b0;
    while (!done) begin
      tok = '0;
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        done = 1'b1;
      end else if (tok == "#") begin
        code = $fgets(line, fd); // comment line
      end else if (tok == "w" && num_words < 64) begin
        code = $fscanf(fd, "%h", word);
        image[num_words] = word;
        num_words++;
      end else if ((tok == "t" || tok == "r") && num_tests < 16) begin
        code = $fscanf(fd, "%d", cycles);
        run_len[num_tests] = cycles;
        pat_rand[num_tests] = (tok == "r");
        pat_str[num_tests] = '0;
        if (tok == "t") begin
          tok = '0;
          code = $fscanf(fd, "%s", tok);
          pat_str[num_tests] = tok;
        end
        pat_len[num_tests] = count_chars(pat_str[num_tests]);
        num_tests++;
      end else begin
        $display("Unknown or excess entry in stimulus file");
        done = 1'b1;
        num_tests = 0;
      end
    end
    $fclose(fd);
    ok = (num_words > 0) && (num_tests > 0);
  endtask

  task automatic run_test(input int t);
    int               cyc;
    int               checked;
    logic             prev_jal;
    logic             prev_stall;
    fs_to_ds_bus_t    prev_bus;
    logic [PC_WD-1:0] ref_pc;
    logic [31:0]      exp_inst;
    logic             all_high;
    test_errors = 0;
    checked     = 0;
    prev_jal    = 1'b0;
    prev_stall  = 1'b0;
    prev_bus    = '0;
    ref_pc      = PC_RESETVAL;
    all_high    = is_all_high(t);
    if (t > 0) begin
      @(posedge clk);
      #2;
      reset = 1'b1;
      es_allowin = 1'b1;
    end
    @(posedge clk); // first reset edge
    @(negedge clk);
    check_value("o_ds_to_es_valid", ds_to_es_valid, 0);
    check_value("o_inst_sram_ren", sram_ren, 1);
    check_value("o_inst_sram_addr", sram_addr, PC_RESETVAL);
    @(posedge clk);
    #2;
    reset = 1'b0;
    es_allowin = allowin_at(t, 0);
    @(negedge clk);
    check_value("o_ds_to_es_valid", ds_to_es_valid, 0);
    check_value("o_inst_sram_ren", sram_ren, 1);
    check_value("o_inst_sram_addr", sram_addr, PC_RESETVAL);
    for (cyc = 1; cyc <= run_len[t]; cyc++) begin
      @(posedge clk);
      #2;
      es_allowin = allowin_at(t, cyc);
      @(negedge clk);
      // first output two cycles after the reset vector read
      if (cyc <= 2) check_value("o_ds_to_es_valid", ds_to_es_valid, cyc == 2);
      else if (all_high) check_value("o_ds_to_es_valid", ds_to_es_valid, !prev_jal);
      if (prev_stall) begin
        check_value("o_ds_to_es_valid", ds_to_es_valid, 1);
        check_value("o_ds_to_es_bus.pc", ds_to_es_bus.pc, prev_bus.pc);
        check_value("o_ds_to_es_bus.inst", ds_to_es_bus.inst, prev_bus.inst);
      end
      prev_jal   = 1'b0;
      prev_stall = ds_to_es_valid && !es_allowin;
      prev_bus   = ds_to_es_bus;
      if (ds_to_es_valid && es_allowin) begin
        exp_inst = expected_inst(ref_pc);
        check_value("o_ds_to_es_bus.pc", ds_to_es_bus.pc, ref_pc);
        check_value("o_ds_to_es_bus.inst", ds_to_es_bus.inst, exp_inst);
        checked++;
        if (exp_inst[6:0] == OPCODE_JAL) begin
          prev_jal = 1'b1;
          ref_pc = jal_target(ref_pc, exp_inst);
        end else begin
          ref_pc = ref_pc + 64'd4;
        end
      end
    end
    if (checked == 0) begin
      $display("No instruction left decode during test %0d", t);
      test_errors++;
    end
    $display("test %0d done: %0d instructions checked, %0d errors", t, checked, test_errors);
    total_errors += test_errors;
    if (test_errors != 0) tests_failed++;
  endtask

  initial begin : watchdog
    wait (limit_cycles > 0);
    #(limit_cycles * 40);
    $display("Timeout after %0d cycles, the tests did not finish", limit_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    logic ok;
    int   total_asserts;
    reset        = 1'b1;
    es_allowin   = 1'b1;
    seed         = 32'h3d44_e9ed;
    total_errors = 0;
    tests_failed = 0;
    for (int i = 0; i < 64; i++) image[i] = fill_word(PC_RESETVAL + 64'(i) * 64'd8);
    read_stimulus(ok);
    if (!ok) begin
      $display("Stimulus file is missing, malformed or holds no program or tests");
      total_errors = 1;
    end else begin
      for (int t = 0; t < num_tests; t++) limit_cycles += run_len[t] + 4;
      limit_cycles += 20;
      for (int t = 0; t < num_tests; t++) run_test(t);
      total_asserts = u_dut.u_id_stage.u_assertions.fail_count;
      total_errors += total_asserts;
      $display("%0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
               num_tests, num_tests - tests_failed, tests_failed, total_errors,
               total_asserts);
    end
    if (total_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
